//--- source/csr_pkg.sv
/*
 * Shared types and constants for the Zicsr CSR path.
 * Holds the CSR and register index types, the operation kind,
 * the decoded-instruction struct and the SYSTEM opcode fields.
 * Modules pull this in with a wildcard import in their header.
 */
`default_nettype none

package csr_pkg;

    // ******************************
    // Sizes and index types
    // ******************************

    // Entries in the flat CSR file
    localparam int CSR_DEPTH = 32;

    typedef logic [4:0] csr_addr_t;
    typedef logic [4:0] reg_addr_t;
    typedef logic [6:0] opcode_t;
    typedef logic [2:0] funct3_t;

    // Encoding follows funct3[1:0] of the Zicsr group
    typedef enum logic [1:0] {
        CSR_OP_WRITE = 2'b01,
        CSR_OP_SET   = 2'b10,
        CSR_OP_CLEAR = 2'b11
    } csr_op_e;

    // Control fields only, 20 bits
    typedef struct packed {
        csr_op_e    op;
        logic       use_imm;   // source is zimm, not rs1
        logic [4:0] zimm;      // rs1 field as an immediate
        reg_addr_t  rd;
        csr_addr_t  csr_addr;
        logic       csr_we;
        logic       illegal;
    } csr_dec_t;

    // ******************************
    // Instruction field constants
    // ******************************
    localparam opcode_t OPCODE_SYSTEM = 7'b1110011;

    localparam funct3_t FUNCT3_CSRRW  = 3'b001;
    localparam funct3_t FUNCT3_CSRRS  = 3'b010;
    localparam funct3_t FUNCT3_CSRRC  = 3'b011;
    localparam funct3_t FUNCT3_CSRRWI = 3'b101;
    localparam funct3_t FUNCT3_CSRRSI = 3'b110;
    localparam funct3_t FUNCT3_CSRRCI = 3'b111;

endpackage

`default_nettype wire

//--- source/csr_decode.sv
/*
 * Decode stage of the CSR path.
 * Splits the instruction word, maps funct3 to the operation, flags
 * illegal encodings and decides whether the CSR is written.
 * The result and the rs1 value are registered on a valid strobe.
 */
`timescale 1ns/1ps
`default_nettype none

module csr_decode
    import csr_pkg::*;
#(
    parameter int XLEN = 32
) (
    input  logic            clk,
    input  logic            reset_i,
    input  logic            instr_valid_i,
    input  logic [31:0]     instr_i,
    input  logic [XLEN-1:0] rs1_data_i,
    output logic            dec_valid_o,
    output csr_dec_t        dec_o,
    output logic [XLEN-1:0] rs1_data_o
);

    opcode_t     opcode;
    funct3_t     funct3;
    reg_addr_t   rd_field;
    reg_addr_t   rs1_field;
    logic [11:0] csr_field;
    logic        funct3_ok;
    csr_dec_t    dec_next;

    // I-type field split
    assign opcode    = instr_i[6:0];
    assign rd_field  = instr_i[11:7];
    assign funct3    = instr_i[14:12];
    assign rs1_field = instr_i[19:15];
    assign csr_field = instr_i[31:20];

    // ******************************
    // Field decode
    // ******************************
    always_comb begin
        dec_next.op      = CSR_OP_WRITE;
        dec_next.use_imm = 1'b0;
        funct3_ok        = 1'b1;

        case (funct3)
            FUNCT3_CSRRW:  dec_next.op = CSR_OP_WRITE;
            FUNCT3_CSRRS:  dec_next.op = CSR_OP_SET;
            FUNCT3_CSRRC:  dec_next.op = CSR_OP_CLEAR;
            FUNCT3_CSRRWI: begin
                dec_next.op      = CSR_OP_WRITE;
                dec_next.use_imm = 1'b1;
            end
            FUNCT3_CSRRSI: begin
                dec_next.op      = CSR_OP_SET;
                dec_next.use_imm = 1'b1;
            end
            FUNCT3_CSRRCI: begin
                dec_next.op      = CSR_OP_CLEAR;
                dec_next.use_imm = 1'b1;
            end
            // ECALL/EBREAK and reserved codes
            default:       funct3_ok = 1'b0;
        endcase

        dec_next.zimm     = rs1_field;
        dec_next.rd       = rd_field;
        dec_next.csr_addr = csr_field[4:0];

        // Only the low 32 CSR numbers are implemented
        dec_next.illegal = (opcode != OPCODE_SYSTEM) || !funct3_ok ||
                           (csr_field[11:5] != 7'd0);

        // Set/clear with a zero source leave the CSR alone
        dec_next.csr_we = !dec_next.illegal &&
                          (dec_next.csr_addr != csr_addr_t'(0)) &&
                          ((dec_next.op == CSR_OP_WRITE) || (rs1_field != reg_addr_t'(0)));
    end

    // ******************************
    // Decode stage register
    // ******************************
    always_ff @(posedge clk) begin
        if (reset_i) begin
            dec_valid_o <= 1'b0;
        end else begin
            dec_valid_o <= instr_valid_i;
        end
    end

    // Payload only follows a valid strobe
    always_ff @(posedge clk) begin
        if (instr_valid_i) begin
            dec_o      <= dec_next;
            rs1_data_o <= rs1_data_i;
        end
    end

endmodule

`default_nettype wire

//--- source/csr_execute.sv
/*
 * Execute stage of the CSR path, purely combinational.
 * Drives the CSR read address, picks rs1 or the zero-extended
 * immediate as the source and forms the new CSR value.
 * Outputs feed the result stage register directly.
 */
`timescale 1ns/1ps
`default_nettype none

module csr_execute
    import csr_pkg::*;
#(
    parameter int XLEN = 32
) (
    input  logic            dec_valid_i,
    input  csr_dec_t        dec_i,
    input  logic [XLEN-1:0] rs1_data_i,
    output csr_addr_t       csr_addr_o,
    input  logic [XLEN-1:0] csr_old_i,
    output logic            ex_valid_o,
    output csr_dec_t        ex_dec_o,
    output logic [XLEN-1:0] csr_old_o,
    output logic [XLEN-1:0] csr_new_o
);

    logic [XLEN-1:0] src;

    // Read port of the CSR file, forwarding happens there
    assign csr_addr_o = dec_i.csr_addr;

    // ******************************
    // Source operand
    // ******************************
    always_comb begin
        if (dec_i.use_imm) begin
            // zimm is unsigned, upper bits zero
            src = XLEN'(dec_i.zimm);
        end else begin
            src = rs1_data_i;
        end
    end

    // ******************************
    // New value
    // ******************************
    always_comb begin
        case (dec_i.op)
            CSR_OP_SET:   csr_new_o = csr_old_i | src;
            CSR_OP_CLEAR: csr_new_o = csr_old_i & ~src;
            // Plain write
            default:      csr_new_o = src;
        endcase
    end

    // Hand over to result stage
    assign ex_valid_o = dec_valid_i;
    assign ex_dec_o   = dec_i;

    // Old value goes back to rd
    assign csr_old_o  = csr_old_i;

endmodule

`default_nettype wire

//--- source/csr_result.sv
/*
 * Result stage of the CSR path.
 * Registers the execute outputs, then drives the CSR write port
 * and the rd writeback for one cycle, or pulses the illegal flag.
 * The CSR write lands in the file on the following edge.
 */
`timescale 1ns/1ps
`default_nettype none

module csr_result
    import csr_pkg::*;
#(
    parameter int XLEN = 32
) (
    input  logic            clk,
    input  logic            reset_i,
    input  logic            ex_valid_i,
    input  csr_dec_t        ex_dec_i,
    input  logic [XLEN-1:0] csr_old_i,
    input  logic [XLEN-1:0] csr_new_i,
    output logic            wr_en_o,
    output csr_addr_t       wr_addr_o,
    output logic [XLEN-1:0] wr_data_o,
    output logic            rd_we_o,
    output reg_addr_t       rd_addr_o,
    output logic [XLEN-1:0] rd_data_o,
    output logic            illegal_o
);

    logic            res_valid;
    csr_dec_t        res_dec;
    logic [XLEN-1:0] res_old;
    logic [XLEN-1:0] res_new;

    // ******************************
    // Stage register
    // ******************************
    always_ff @(posedge clk) begin
        if (reset_i) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= ex_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        res_dec <= ex_dec_i;
        res_old <= csr_old_i;
        res_new <= csr_new_i;
    end

    // CSR write port, csr_we already excludes illegal and index 0
    assign wr_en_o   = res_valid && res_dec.csr_we;
    assign wr_addr_o = res_dec.csr_addr;
    assign wr_data_o = res_new;

    // rd writeback, x0 never written
    assign rd_we_o   = res_valid && !res_dec.illegal && (res_dec.rd != reg_addr_t'(0));
    assign rd_addr_o = res_dec.rd;
    assign rd_data_o = res_old;

    // One-cycle flag per bad instruction
    assign illegal_o = res_valid && res_dec.illegal;

endmodule

`default_nettype wire

//--- source/csr_file.sv
/*
 * Flat CSR storage, CSR_DEPTH entries of XLEN bits.
 * One combinational read port and one write port; a read of the
 * index being written sees the write data in the same cycle.
 * Entry 0 reads as zero and ignores writes.
 */
`timescale 1ns/1ps
`default_nettype none

module csr_file
    import csr_pkg::*;
#(
    parameter int XLEN = 32
) (
    input  logic            clk,
    input  logic            reset_i,
    input  csr_addr_t       rd_addr_i,
    output logic [XLEN-1:0] rd_data_o,
    input  logic            wr_en_i,
    input  csr_addr_t       wr_addr_i,
    input  logic [XLEN-1:0] wr_data_i
);

    logic [XLEN-1:0] mem [CSR_DEPTH];

    // ******************************
    // Read with forwarding
    // ******************************
    always_comb begin
        if (rd_addr_i == csr_addr_t'(0)) begin
            rd_data_o = '0;
        end else if (wr_en_i && (wr_addr_i == rd_addr_i)) begin
            // Pending write from the result stage wins
            rd_data_o = wr_data_i;
        end else begin
            rd_data_o = mem[rd_addr_i];
        end
    end

    // ******************************
    // Write and reset clear
    // ******************************
    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < CSR_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (wr_en_i && (wr_addr_i != csr_addr_t'(0))) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

endmodule

`default_nettype wire

//--- source/csr_unit.sv
/*
 * Top of the CSR path: decode, execute, result and CSR file.
 * Takes one Zicsr instruction per cycle with its rs1 value and
 * returns the old CSR value for rd two cycles later.
 * XLEN is set here and passed to every block.
 */
`timescale 1ns/1ps
`default_nettype none

module csr_unit
    import csr_pkg::*;
#(
    parameter int XLEN = 32
) (
    input  logic            clk,
    input  logic            reset_i,
    input  logic            instr_valid_i,
    input  logic [31:0]     instr_i,
    input  logic [XLEN-1:0] rs1_data_i,
    output logic            rd_we_o,
    output reg_addr_t       rd_addr_o,
    output logic [XLEN-1:0] rd_data_o,
    output logic            illegal_o
);

    // Decode to execute
    logic            dec_valid;
    csr_dec_t        dec;
    logic [XLEN-1:0] dec_rs1;

    // Execute to file and result
    csr_addr_t       rd_csr_addr;
    logic [XLEN-1:0] csr_rd_data;
    logic            ex_valid;
    csr_dec_t        ex_dec;
    logic [XLEN-1:0] csr_old;
    logic [XLEN-1:0] csr_new;

    // Result to file
    logic            wr_en;
    csr_addr_t       wr_addr;
    logic [XLEN-1:0] wr_data;

    // ******************************
    // Pipeline
    // ******************************
    csr_decode #(.XLEN(XLEN)) u_decode (
        .clk           (clk),
        .reset_i       (reset_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .rs1_data_i    (rs1_data_i),
        .dec_valid_o   (dec_valid),
        .dec_o         (dec),
        .rs1_data_o    (dec_rs1)
    );

    csr_execute #(.XLEN(XLEN)) u_execute (
        .dec_valid_i (dec_valid),
        .dec_i       (dec),
        .rs1_data_i  (dec_rs1),
        .csr_addr_o  (rd_csr_addr),
        .csr_old_i   (csr_rd_data),
        .ex_valid_o  (ex_valid),
        .ex_dec_o    (ex_dec),
        .csr_old_o   (csr_old),
        .csr_new_o   (csr_new)
    );

    csr_result #(.XLEN(XLEN)) u_result (
        .clk        (clk),
        .reset_i    (reset_i),
        .ex_valid_i (ex_valid),
        .ex_dec_i   (ex_dec),
        .csr_old_i  (csr_old),
        .csr_new_i  (csr_new),
        .wr_en_o    (wr_en),
        .wr_addr_o  (wr_addr),
        .wr_data_o  (wr_data),
        .rd_we_o    (rd_we_o),
        .rd_addr_o  (rd_addr_o),
        .rd_data_o  (rd_data_o),
        .illegal_o  (illegal_o)
    );

    // Storage with forwarding from the result stage
    csr_file #(.XLEN(XLEN)) u_file (
        .clk       (clk),
        .reset_i   (reset_i),
        .rd_addr_i (rd_csr_addr),
        .rd_data_o (csr_rd_data),
        .wr_en_i   (wr_en),
        .wr_addr_i (wr_addr),
        .wr_data_i (wr_data)
    );

endmodule

`default_nettype wire

//--- testbench/tb_csr_unit.sv
/*
 * Testbench for the CSR unit.
 * Issues a random Zicsr instruction stream from a fixed seed and
 * compares rd writeback and the illegal flag two cycles later
 * against a CSR model that is updated in issue order.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_csr_unit;

    localparam int XLEN       = 32;
    localparam int CLK_PERIOD = 8;
    localparam int N_RAND     = 200;
    localparam int N_IMM      = 120;
    localparam int N_B2B      = 16;
    localparam int N_ZERO     = 40;
    localparam int N_ILL      = 60;
    // Five full read sweeps, idle gaps at most one per random op
    localparam int TOTAL_CYCLES = 3 + 5 * 34 + 2 * N_RAND + 2 * N_IMM + 5 * N_B2B
                                + N_ZERO + N_ILL + 6 * 2;
    localparam int MARGIN     = 100;

    // Expected outputs of one issue slot
    typedef struct packed {
        logic            valid;
        logic            we;
        logic            ill;
        logic [4:0]      rd;
        logic [XLEN-1:0] data;
    } expect_t;

    logic            clk = 1'b0;
    logic            reset_i;
    logic            instr_valid_i;
    logic [31:0]     instr_i;
    logic [XLEN-1:0] rs1_data_i;
    logic            rd_we_o;
    logic [4:0]      rd_addr_o;
    logic [XLEN-1:0] rd_data_o;
    logic            illegal_o;

    logic [XLEN-1:0] model_csr [32];
    expect_t         exp_q [$];
    int              n_checks = 0;
    int              n_errors = 0;
    int              mark_checks;
    int              mark_errors;

    always #(CLK_PERIOD / 2) clk = ~clk;

    csr_unit #(.XLEN(XLEN)) i_dut (
        .clk           (clk),
        .reset_i       (reset_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .rs1_data_i    (rs1_data_i),
        .rd_we_o       (rd_we_o),
        .rd_addr_o     (rd_addr_o),
        .rd_data_o     (rd_data_o),
        .illegal_o     (illegal_o)
    );

    // ******************************
    // Helpers
    // ******************************

    // SYSTEM-opcode I-type word
    function automatic logic [31:0] make_instr(input logic [2:0] f3, input logic [11:0] csr,
                                               input logic [4:0] rs1f, input logic [4:0] rd);
        return {csr, rs1f, f3, rd, 7'b1110011};
    endfunction

    // Random legal funct3, imm selects the I forms
    function automatic logic [2:0] random_f3(input logic imm);
        return {imm, 2'($urandom_range(3, 1))};
    endfunction

    // Compare DUT outputs with the oldest expectation
    task automatic check_outputs();
        expect_t e;
        e = exp_q.pop_front();
        n_checks++;
        if (rd_we_o !== e.we) begin
            $display("Fail rd_we_o: got %h, expected %h", rd_we_o, e.we);
            n_errors++;
        end
        if (illegal_o !== (e.valid && e.ill)) begin
            $display("Fail illegal_o: got %h, expected %h", illegal_o, e.valid && e.ill);
            n_errors++;
        end
        if (e.we && (rd_addr_o !== e.rd)) begin
            $display("Fail rd_addr_o: got %h, expected %h", rd_addr_o, e.rd);
            n_errors++;
        end
        // Old value is returned for any legal instruction
        if (e.valid && !e.ill && (rd_data_o !== e.data)) begin
            $display("Fail rd_data_o: got %h, expected %h", rd_data_o, e.data);
            n_errors++;
        end
    endtask

    // Outputs of the slot issued two falling edges ago are stable here
    task automatic next_cycle();
        @(negedge clk);
        if (exp_q.size() == 2) begin
            check_outputs();
        end
    endtask

    task automatic idle_cycle();
        expect_t e;
        next_cycle();
        instr_valid_i = 1'b0;
        instr_i       = $urandom();
        rs1_data_i    = $urandom();
        e = '0;
        exp_q.push_back(e);
    endtask

    // Drive one instruction and run it through the model
    task automatic issue_instr(input logic [31:0] instr, input logic [XLEN-1:0] rs1);
        logic [2:0]      f3;
        logic [11:0]     csr;
        logic [4:0]      rs1f;
        logic [4:0]      rd;
        logic [4:0]      idx;
        logic            legal;
        logic            write;
        logic [XLEN-1:0] src;
        logic [XLEN-1:0] old_val;
        logic [XLEN-1:0] new_val;
        expect_t         e;
        next_cycle();
        instr_valid_i = 1'b1;
        instr_i       = instr;
        rs1_data_i    = rs1;

        f3   = instr[14:12];
        csr  = instr[31:20];
        rs1f = instr[19:15];
        rd   = instr[11:7];
        idx  = csr[4:0];
        // funct3 0 and 4 are not CSR codes
        legal = (instr[6:0] == 7'b1110011) && (f3 != 3'd0) && (f3 != 3'd4) &&
                (csr[11:5] == 7'd0);
        old_val = (idx == 5'd0) ? '0 : model_csr[idx];
        src     = f3[2] ? {{(XLEN-5){1'b0}}, rs1f} : rs1;
        case (f3[1:0])
            2'b10:   new_val = old_val | src;
            2'b11:   new_val = old_val & ~src;
            default: new_val = src;
        endcase
        // Set/clear with a zero field leave the CSR alone
        write = legal && (idx != 5'd0) && ((f3[1:0] == 2'b01) || (rs1f != 5'd0));
        if (write) begin
            model_csr[idx] = new_val;
        end

        e.valid = 1'b1;
        e.we    = legal && (rd != 5'd0);
        e.ill   = !legal;
        e.rd    = rd;
        e.data  = old_val;
        exp_q.push_back(e);
    endtask

    // CSRRS with a zero field to every index, a pure read
    task automatic read_all_csrs();
        for (int i = 0; i < 32; i++) begin
            issue_instr(make_instr(3'b010, 12'(i), 5'd0, 5'($urandom_range(31, 1))),
                        $urandom());
        end
    endtask

    task automatic begin_test();
        mark_checks = n_checks;
        mark_errors = n_errors;
    endtask

    // Flush the pipe so every slot of the test is checked
    task automatic end_test(input string name);
        repeat (2) idle_cycle();
        $display("test %-12s %0d checks, %0d errors", name,
                 n_checks - mark_checks, n_errors - mark_errors);
    endtask

    // ******************************
    // Watchdog
    // ******************************
    initial begin
        #((TOTAL_CYCLES + MARGIN) * CLK_PERIOD);
        $display("Timeout: run did not finish within %0d cycles", TOTAL_CYCLES + MARGIN);
        $display("RESULT: FAIL");
        $finish;
    end

    // ******************************
    // Stimulus
    // ******************************
    initial begin
        logic [2:0] f3;
        logic [4:0] idx;
        logic [6:0] bad_op;
        logic [31:0] instr;
        reset_i       = 1'b1;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        rs1_data_i    = '0;
        void'($urandom(32'h21c1));
        for (int i = 0; i < 32; i++) begin
            model_csr[i] = '0;
        end
        repeat (3) @(negedge clk);
        reset_i = 1'b0;

        // All entries read zero after reset, rd = index
        begin_test();
        for (int i = 0; i < 32; i++) begin
            issue_instr(make_instr(3'b010, 12'(i), 5'd0, 5'(i)), $urandom());
        end
        end_test("reset_reads");

        // Register forms with random rs1 values, random gaps
        begin_test();
        for (int n = 0; n < N_RAND; n++) begin
            if ($urandom_range(3) == 0) begin
                idle_cycle();
            end
            issue_instr(make_instr(random_f3(1'b0), 12'($urandom_range(31)),
                                   5'($urandom()), 5'($urandom())), $urandom());
        end
        read_all_csrs();
        end_test("reg_ops");

        // Immediate forms, a quarter with a zero field
        begin_test();
        for (int n = 0; n < N_IMM; n++) begin
            if ($urandom_range(3) == 0) begin
                idle_cycle();
            end
            instr = make_instr(random_f3(1'b1), 12'($urandom_range(31, 1)),
                               ($urandom_range(3) == 0) ? 5'd0 : 5'($urandom()),
                               5'($urandom()));
            issue_instr(instr, $urandom());
        end
        read_all_csrs();
        end_test("imm_ops");

        // Same index on consecutive cycles, ends with a read
        begin_test();
        for (int g = 0; g < N_B2B; g++) begin
            idx = 5'($urandom_range(31, 1));
            repeat (4) begin
                f3 = random_f3(1'($urandom()));
                issue_instr(make_instr(f3, 12'(idx), 5'($urandom()), 5'($urandom())),
                            $urandom());
            end
            issue_instr(make_instr(3'b010, 12'(idx), 5'd0, 5'd1), $urandom());
        end
        end_test("back_to_back");

        // Index 0 writes, and rd = x0 on other indexes
        begin_test();
        for (int n = 0; n < N_ZERO; n++) begin
            idx = ($urandom_range(1) == 0) ? 5'd0 : 5'($urandom_range(31, 1));
            f3  = random_f3(1'($urandom()));
            instr = make_instr(f3, 12'(idx), 5'($urandom()),
                               (idx == 5'd0) ? 5'($urandom()) : 5'd0);
            issue_instr(instr, $urandom());
        end
        read_all_csrs();
        end_test("zero_index");

        // Bad opcode, bad funct3 or upper CSR bits set
        begin_test();
        for (int n = 0; n < N_ILL; n++) begin
            instr = make_instr(random_f3(1'($urandom())), 12'($urandom_range(31, 1)),
                               5'($urandom_range(31, 1)), 5'($urandom_range(31, 1)));
            case ($urandom_range(2))
                0: begin
                    bad_op = 7'($urandom());
                    if (bad_op == 7'b1110011) begin
                        bad_op = 7'b0110011;
                    end
                    instr[6:0] = bad_op;
                end
                1: instr[14:12] = ($urandom_range(1) == 0) ? 3'd0 : 3'd4;
                default: instr[31:25] = 7'($urandom_range(127, 1));
            endcase
            issue_instr(instr, $urandom());
        end
        read_all_csrs();
        end_test("illegal");

        $display("total %0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
source/csr_pkg.sv
source/csr_decode.sv
source/csr_execute.sv
source/csr_result.sv
source/csr_file.sv
source/csr_unit.sv
testbench/tb_csr_unit.sv
